// File: common/marble_pkg.sv
// Marble test build shared definitions
package marble_pkg;

	// APB between SPI bridge and register bank
	localparam int APB_AW = 8;
	localparam int APB_DW = 16;

	// Register word addresses
	localparam logic [APB_AW-1:0] ADDR_ID        = 8'h00;
	localparam logic [APB_AW-1:0] ADDR_LED       = 8'h01;
	localparam logic [APB_AW-1:0] ADDR_CTRL      = 8'h02;
	localparam logic [APB_AW-1:0] ADDR_TX_CMD    = 8'h03;
	localparam logic [APB_AW-1:0] ADDR_RX_FRAMES = 8'h04;
	localparam logic [APB_AW-1:0] ADDR_RX_BYTES  = 8'h05;
	localparam logic [APB_AW-1:0] ADDR_RX_SUM    = 8'h06;

	localparam logic [APB_DW-1:0] MARBLE_ID = 16'h4d31;

	// PHY reset stretch after rst_n release
	localparam int PHY_RST_CYCLES = 64;
	localparam int PHY_CNT_W      = $clog2(PHY_RST_CYCLES + 1);

	// SPI frame is 8 header bits then 16 data bits
	localparam int SPI_HDR_BITS   = 8;
	localparam int SPI_FRAME_BITS = 24;
	localparam int SPI_CNT_W      = $clog2(SPI_FRAME_BITS);

	typedef enum logic [2:0] {
		SPI_IDLE,
		SPI_HEADER,
		SPI_APB_SETUP,
		SPI_APB_ACCESS,
		SPI_DATA
	} spi_state_t;

	typedef enum logic {
		TX_IDLE,
		TX_SEND
	} tx_state_t;

endpackage

// File: rgmii/gmii_to_rgmii.sv
// GMII to RGMII DDR conversion
module gmii_to_rgmii (
	input  logic       sysclk,
	input  logic       rst_n,
	output logic [3:0] rgmii_txd,
	output logic       rgmii_tx_ctrl,
	output logic       rgmii_tx_clk,
	input  logic       rgmii_rx_clk,
	input  logic [3:0] rgmii_rxd,
	input  logic       rgmii_rx_ctrl,
	input  logic [7:0] gmii_txd,
	input  logic       gmii_tx_en,
	input  logic       gmii_tx_er,
	output logic [7:0] gmii_rxd,
	output logic       gmii_rx_dv,
	output logic       gmii_rx_er
);
	logic [3:0] txd_rise;
	logic [3:0] txd_hold;
	logic [3:0] txd_fall;
	logic       ctl_rise;
	logic       ctl_hold;
	logic       ctl_fall;
	logic [3:0] rxd_rise;
	logic [3:0] rxd_fall;
	logic       rx_ctl_rise;
	logic       rx_ctl_fall;

	// Transmit, in-phase clock
	assign rgmii_tx_clk = sysclk;

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			ctl_rise <= 1'b0;
			ctl_hold <= 1'b0;
		end else begin
			ctl_rise <= gmii_tx_en;
			ctl_hold <= gmii_tx_en ^ gmii_tx_er;
		end
	end

	always_ff @(posedge sysclk) begin
		txd_rise <= gmii_txd[3:0];
		txd_hold <= gmii_txd[7:4];
	end

	// High half moves to the falling edge
	always_ff @(negedge sysclk or negedge rst_n) begin
		if (!rst_n)
			ctl_fall <= 1'b0;
		else
			ctl_fall <= ctl_hold;
	end

	always_ff @(negedge sysclk) begin
		txd_fall <= txd_hold;
	end

	// Output mux acts as the DDR output flop
	assign rgmii_txd     = sysclk ? txd_rise : txd_fall;
	assign rgmii_tx_ctrl = sysclk ? ctl_rise : ctl_fall;

	// Receive clock taken as center-aligned to the data, as a PHY with RX delay gives it
	always_ff @(posedge rgmii_rx_clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_ctl_rise <= 1'b0;
			gmii_rx_dv  <= 1'b0;
			gmii_rx_er  <= 1'b0;
		end else begin
			rx_ctl_rise <= rgmii_rx_ctrl;
			gmii_rx_dv  <= rx_ctl_rise;
			gmii_rx_er  <= rx_ctl_rise ^ rx_ctl_fall;
		end
	end

	always_ff @(posedge rgmii_rx_clk) begin
		rxd_rise <= rgmii_rxd;
		gmii_rxd <= {rxd_fall, rxd_rise};
	end

	always_ff @(negedge rgmii_rx_clk or negedge rst_n) begin
		if (!rst_n)
			rx_ctl_fall <= 1'b0;
		else
			rx_ctl_fall <= rgmii_rx_ctrl;
	end

	always_ff @(negedge rgmii_rx_clk) begin
		rxd_fall <= rgmii_rxd;
	end

endmodule

// File: base/spi_apb_bridge.sv
// SPI mode-0 slave to APB master bridge
module spi_apb_bridge import marble_pkg::*; (
	input  logic              sysclk,
	input  logic              rst_n,
	input  logic              sclk,
	input  logic              csb,
	input  logic              mosi,
	output logic              miso,
	output logic              psel,
	output logic              penable,
	output logic              pwrite,
	output logic [APB_AW-1:0] paddr,
	output logic [APB_DW-1:0] pwdata,
	input  logic              pready,
	input  logic              pslverr,
	input  logic [APB_DW-1:0] prdata
);
	logic [1:0]           sclk_s;
	logic [1:0]           csb_s;
	logic [1:0]           mosi_s;
	logic                 sclk_rise;
	logic                 sclk_fall;
	logic                 csb_fall;
	logic                 hdr_done;
	spi_state_t           state;
	logic [SPI_CNT_W-1:0] bit_cnt;
	logic [APB_DW-1:0]    sr;
	logic                 rd_q;
	logic [APB_AW-2:0]    addr_q;

	// Two-flop synchronizers, edges taken between the two stages
	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			sclk_s <= '0;
			csb_s  <= '1;
			mosi_s <= '0;
		end else begin
			sclk_s <= {sclk_s[0], sclk};
			csb_s  <= {csb_s[0], csb};
			mosi_s <= {mosi_s[0], mosi};
		end
	end

	assign sclk_rise = sclk_s[0] & ~sclk_s[1];
	assign sclk_fall = ~sclk_s[0] & sclk_s[1];
	assign csb_fall  = ~csb_s[0] & csb_s[1];
	assign hdr_done  = sclk_rise && bit_cnt == SPI_CNT_W'(SPI_HDR_BITS - 1);

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= SPI_IDLE;
			bit_cnt <= '0;
			rd_q    <= 1'b0;
			miso    <= 1'b0;
		end else begin
			case (state)
				SPI_IDLE: begin
					miso    <= 1'b0;
					bit_cnt <= '0;
					if (csb_fall)
						state <= SPI_HEADER;
				end
				SPI_HEADER: begin
					if (csb_s[1]) begin
						state <= SPI_IDLE;
					end else if (sclk_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
						// First header bit is the read flag
						if (hdr_done) begin
							rd_q  <= sr[6];
							state <= sr[6] ? SPI_APB_SETUP : SPI_DATA;
						end
					end
				end
				SPI_DATA: begin
					if (csb_s[1]) begin
						state <= SPI_IDLE;
					end else begin
						if (sclk_fall && rd_q)
							miso <= sr[APB_DW-1];
						if (sclk_rise) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == SPI_CNT_W'(SPI_FRAME_BITS - 1))
								state <= rd_q ? SPI_IDLE : SPI_APB_SETUP;
						end
					end
				end
				SPI_APB_SETUP: state <= SPI_APB_ACCESS;
				SPI_APB_ACCESS: begin
					if (pready)
						state <= rd_q ? SPI_DATA : SPI_IDLE;
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	// Shift register serves mosi capture and miso readout
	always_ff @(posedge sysclk) begin
		if (state == SPI_APB_ACCESS && pready && rd_q)
			sr <= pslverr ? '0 : prdata;
		else if ((state == SPI_HEADER || state == SPI_DATA) && sclk_rise)
			sr <= {sr[APB_DW-2:0], mosi_s[1]};
		if (state == SPI_HEADER && hdr_done)
			addr_q <= {sr[5:0], mosi_s[1]};
	end

	assign psel    = (state == SPI_APB_SETUP) || (state == SPI_APB_ACCESS);
	assign penable = state == SPI_APB_ACCESS;
	assign pwrite  = ~rd_q;
	assign paddr   = {1'b0, addr_q};
	assign pwdata  = sr;

endmodule

// File: base/marble_regs.sv
// APB register bank
module marble_regs import marble_pkg::*; (
	input  logic              sysclk,
	input  logic              rst_n,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [APB_AW-1:0] paddr,
	input  logic [APB_DW-1:0] pwdata,
	output logic              pready,
	output logic              pslverr,
	output logic [APB_DW-1:0] prdata,
	input  logic              tx_busy,
	input  logic [15:0]       rx_frames,
	input  logic [15:0]       rx_bytes,
	input  logic [15:0]       rx_sum,
	output logic [7:0]        led,
	output logic              phy_rst_req,
	output logic              zest_pwr_en,
	output logic              tx_start,
	output logic [7:0]        tx_len,
	output logic [7:0]        tx_seed
);
	logic [1:0] ctrl_q;
	logic       wr_en;
	logic       addr_hit;

	// Zero wait states
	assign pready  = psel & penable;
	assign wr_en   = psel & penable & pwrite;
	assign pslverr = psel & penable & ~addr_hit;

	always_comb begin
		addr_hit = 1'b1;
		prdata   = '0;
		case (paddr)
			ADDR_ID:        prdata = MARBLE_ID;
			ADDR_LED:       prdata = {8'h00, led};
			ADDR_CTRL:      prdata = {14'h0000, ctrl_q};
			ADDR_TX_CMD:    prdata = {15'h0000, tx_busy};
			ADDR_RX_FRAMES: prdata = rx_frames;
			ADDR_RX_BYTES:  prdata = rx_bytes;
			ADDR_RX_SUM:    prdata = rx_sum;
			default:        addr_hit = 1'b0;
		endcase
	end

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			led      <= '0;
			ctrl_q   <= '0;
			tx_start <= 1'b0;
		end else begin
			// Zero length starts nothing
			tx_start <= wr_en && paddr == ADDR_TX_CMD && pwdata[7:0] != 8'h00;
			if (wr_en && paddr == ADDR_LED)
				led <= pwdata[7:0];
			if (wr_en && paddr == ADDR_CTRL)
				ctrl_q <= pwdata[1:0];
		end
	end

	always_ff @(posedge sysclk) begin
		if (wr_en && paddr == ADDR_TX_CMD) begin
			tx_len  <= pwdata[7:0];
			tx_seed <= pwdata[15:8];
		end
	end

	assign phy_rst_req = ctrl_q[0];
	assign zest_pwr_en = ctrl_q[1];

endmodule

// File: base/frame_engine.sv
// GMII test frame generator and receive statistics
module frame_engine import marble_pkg::*; (
	input  logic        sysclk,
	input  logic        rst_n,
	input  logic        tx_start,
	input  logic [7:0]  tx_len,
	input  logic [7:0]  tx_seed,
	input  logic [7:0]  gmii_rxd,
	input  logic        gmii_rx_dv,
	input  logic        gmii_rx_er,
	output logic [7:0]  gmii_txd,
	output logic        gmii_tx_en,
	output logic        gmii_tx_er,
	output logic        tx_busy,
	output logic [15:0] rx_frames,
	output logic [15:0] rx_bytes,
	output logic [15:0] rx_sum
);
	tx_state_t   state;
	logic [7:0]  remain;
	logic        rx_dv_q;
	logic        rx_err_q;
	logic [15:0] cur_bytes;
	logic [15:0] cur_sum;

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= TX_IDLE;
			gmii_tx_en <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (tx_start && tx_len != 8'h00) begin
						state      <= TX_SEND;
						gmii_tx_en <= 1'b1;
					end
				end
				TX_SEND: begin
					if (remain == 8'h00) begin
						state      <= TX_IDLE;
						gmii_tx_en <= 1'b0;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Idle keeps the next frame preloaded
	always_ff @(posedge sysclk) begin
		if (state == TX_IDLE) begin
			gmii_txd <= tx_seed;
			remain   <= tx_len - 8'd1;
		end else begin
			gmii_txd <= gmii_txd + 8'd1;
			remain   <= remain - 8'd1;
		end
	end

	assign gmii_tx_er = 1'b0;
	assign tx_busy    = tx_start | (state == TX_SEND);

	// Receive side, totals committed when rx_dv falls
	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			rx_dv_q   <= 1'b0;
			rx_err_q  <= 1'b0;
			cur_bytes <= '0;
			cur_sum   <= '0;
			rx_frames <= '0;
			rx_bytes  <= '0;
			rx_sum    <= '0;
		end else begin
			rx_dv_q <= gmii_rx_dv;
			if (gmii_rx_dv) begin
				cur_bytes <= cur_bytes + 16'd1;
				cur_sum   <= cur_sum + {8'h00, gmii_rxd};
				if (gmii_rx_er)
					rx_err_q <= 1'b1;
			end else if (rx_dv_q) begin
				// Errored frames are dropped from the totals
				if (!rx_err_q) begin
					rx_frames <= rx_frames + 16'd1;
					rx_bytes  <= rx_bytes + cur_bytes;
					rx_sum    <= rx_sum + cur_sum;
				end
				cur_bytes <= '0;
				cur_sum   <= '0;
				rx_err_q  <= 1'b0;
			end
		end
	end

endmodule

// File: base/marble_base.sv
// Portable Marble base block
module marble_base import marble_pkg::*; (
	input  logic       sysclk,
	input  logic       rst_n,
	input  logic       sclk,
	input  logic       csb,
	input  logic       mosi,
	output logic       miso,
	input  logic [7:0] gmii_rxd,
	input  logic       gmii_rx_dv,
	input  logic       gmii_rx_er,
	output logic [7:0] gmii_txd,
	output logic       gmii_tx_en,
	output logic       gmii_tx_er,
	output logic       phy_rstn,
	output logic       zest_pwr_en,
	output logic [7:0] led
);
	logic                 psel;
	logic                 penable;
	logic                 pwrite;
	logic [APB_AW-1:0]    paddr;
	logic [APB_DW-1:0]    pwdata;
	logic                 pready;
	logic                 pslverr;
	logic [APB_DW-1:0]    prdata;
	logic                 phy_rst_req;
	logic                 tx_start;
	logic [7:0]           tx_len;
	logic [7:0]           tx_seed;
	logic                 tx_busy;
	logic [15:0]          rx_frames;
	logic [15:0]          rx_bytes;
	logic [15:0]          rx_sum;
	logic [PHY_CNT_W-1:0] phy_cnt;
	logic                 phy_cnt_done;

	spi_apb_bridge bridge (
		.sysclk(sysclk), .rst_n(rst_n),
		.sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.pready(pready), .pslverr(pslverr), .prdata(prdata)
	);

	marble_regs regs (
		.sysclk(sysclk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.pready(pready), .pslverr(pslverr), .prdata(prdata),
		.tx_busy(tx_busy), .rx_frames(rx_frames), .rx_bytes(rx_bytes), .rx_sum(rx_sum),
		.led(led), .phy_rst_req(phy_rst_req), .zest_pwr_en(zest_pwr_en),
		.tx_start(tx_start), .tx_len(tx_len), .tx_seed(tx_seed)
	);

	frame_engine engine (
		.sysclk(sysclk), .rst_n(rst_n),
		.tx_start(tx_start), .tx_len(tx_len), .tx_seed(tx_seed),
		.gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.tx_busy(tx_busy), .rx_frames(rx_frames), .rx_bytes(rx_bytes), .rx_sum(rx_sum)
	);

	// PHY reset held low for a fixed count after reset release
	assign phy_cnt_done = phy_cnt == PHY_CNT_W'(PHY_RST_CYCLES);

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n)
			phy_cnt <= '0;
		else if (!phy_cnt_done)
			phy_cnt <= phy_cnt + 1'b1;
	end

	assign phy_rstn = phy_cnt_done & ~phy_rst_req;

endmodule

// File: rtl/marble1.sv
// Marble-Mini board top
module marble1 (
	input  logic       sysclk,
	input  logic       rst_n,
	output logic [3:0] rgmii_txd,
	output logic       rgmii_tx_ctrl,
	output logic       rgmii_tx_clk,
	input  logic [3:0] rgmii_rxd,
	input  logic       rgmii_rx_ctrl,
	input  logic       rgmii_rx_clk,
	input  logic       sclk,
	input  logic       csb,
	input  logic       mosi,
	output logic       miso,
	output logic       phy_rstn,
	output logic       zest_pwr_en,
	output logic [7:0] led
);
	logic [7:0] gmii_txd;
	logic       gmii_tx_en;
	logic       gmii_tx_er;
	logic [7:0] gmii_rxd;
	logic       gmii_rx_dv;
	logic       gmii_rx_er;

	gmii_to_rgmii ddr (
		.sysclk(sysclk), .rst_n(rst_n),
		.rgmii_txd(rgmii_txd), .rgmii_tx_ctrl(rgmii_tx_ctrl), .rgmii_tx_clk(rgmii_tx_clk),
		.rgmii_rx_clk(rgmii_rx_clk), .rgmii_rxd(rgmii_rxd), .rgmii_rx_ctrl(rgmii_rx_ctrl),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er)
	);

	marble_base base (
		.sysclk(sysclk), .rst_n(rst_n),
		.sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso),
		.gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
		.phy_rstn(phy_rstn), .zest_pwr_en(zest_pwr_en), .led(led)
	);

endmodule

// File: dv/marble1_asserts.sv
// APB, PHY reset and GMII pattern checks
module marble1_asserts import marble_pkg::*; (
	input logic              sysclk,
	input logic              rst_n,
	input logic              psel,
	input logic              penable,
	input logic              pwrite,
	input logic [APB_AW-1:0] paddr,
	input logic [APB_DW-1:0] pwdata,
	input logic              phy_rstn,
	input logic [7:0]        gmii_txd,
	input logic              gmii_tx_en
);
	timeunit 1ns;
	timeprecision 100ps;

	int   fail_count = 0;
	logic ctrl_rst_set;

	// CTRL bit 0 as last written over APB
	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n)
			ctrl_rst_set <= 1'b0;
		else if (psel && penable && pwrite && paddr == ADDR_CTRL)
			ctrl_rst_set <= pwdata[0];
	end

	// Access cycle follows exactly one setup cycle
	apb_enable_with_sel: assert property (@(posedge sysclk) disable iff (!rst_n)
		penable |-> psel && $past(psel && !penable))
	else begin
		fail_count++;
		$error("penable high without psel or without a setup cycle before it");
	end

	// Access cycle must keep what the setup cycle presented
	apb_stable_access: assert property (@(posedge sysclk) disable iff (!rst_n)
		psel && penable |-> $stable(paddr) && $stable(pwdata) && $stable(pwrite))
	else begin
		fail_count++;
		$error("APB address, data or direction changed during the access");
	end

	phy_rst_hold: assert property (@(posedge sysclk) disable iff (!rst_n)
		ctrl_rst_set |-> !phy_rstn)
	else begin
		fail_count++;
		$error("phy_rstn high while the CTRL reset request is set");
	end

	// Incrementing byte pattern inside a frame
	tx_pattern: assert property (@(posedge sysclk) disable iff (!rst_n)
		gmii_tx_en && $past(gmii_tx_en) |-> gmii_txd == $past(gmii_txd) + 8'd1)
	else begin
		fail_count++;
		$error("GMII transmit byte is not the previous byte plus one");
	end

endmodule

// File: dv/marble1_tb.sv
// Marble1 board-level testbench
module marble1_tb import marble_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 20000;

	logic       sysclk = 1'b0;
	logic       rst_n;
	logic [3:0] rgmii_txd;
	logic       rgmii_tx_ctrl;
	logic       rgmii_tx_clk;
	logic       rgmii_rx_clk = 1'b0;
	logic       sclk;
	logic       csb;
	logic       mosi;
	logic       miso;
	logic       phy_rstn;
	logic       zest_pwr_en;
	logic [7:0] led;
	int         errors;
	int         cycles;

	// RGMII transmit pins looped back to receive
	marble1 DUT (
		.sysclk(sysclk), .rst_n(rst_n),
		.rgmii_txd(rgmii_txd), .rgmii_tx_ctrl(rgmii_tx_ctrl), .rgmii_tx_clk(rgmii_tx_clk),
		.rgmii_rxd(rgmii_txd), .rgmii_rx_ctrl(rgmii_tx_ctrl), .rgmii_rx_clk(rgmii_rx_clk),
		.sclk(sclk), .csb(csb), .mosi(mosi), .miso(miso),
		.phy_rstn(phy_rstn), .zest_pwr_en(zest_pwr_en), .led(led)
	);

	bind marble_base marble1_asserts asserts (
		.sysclk(sysclk), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.phy_rstn(phy_rstn),
		.gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en)
	);

	always #4 sysclk = ~sysclk;

	// Receive clock lags a quarter period, as a PHY with RX delay gives it
	always @(rgmii_tx_clk)
		rgmii_rx_clk <= #2 rgmii_tx_clk;

	always @(posedge sysclk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// One 24-bit mode-0 frame, one sclk edge every 4 sysclk cycles
	task automatic spi_transfer(input logic [23:0] tx, output logic [23:0] rx);
		rx = '0;
		@(posedge sysclk);
		csb  <= 1'b0;
		mosi <= tx[23];
		for (int i = 23; i >= 0; i--) begin
			repeat (3) @(posedge sysclk);
			// miso taken half a cycle before the rising sclk edge
			@(negedge sysclk);
			rx = {rx[22:0], miso};
			@(posedge sysclk);
			sclk <= 1'b1;
			repeat (4) @(posedge sysclk);
			sclk <= 1'b0;
			if (i > 0)
				mosi <= tx[i-1];
		end
		repeat (4) @(posedge sysclk);
		csb <= 1'b1;
		repeat (8) @(posedge sysclk);
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
		logic [23:0] rx;
		spi_transfer({1'b0, addr[6:0], data}, rx);
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [15:0] data);
		logic [23:0] rx;
		spi_transfer({1'b1, addr[6:0], 16'h0000}, rx);
		data = rx[15:0];
	endtask

	task automatic expect_value(input logic [15:0] got, input logic [15:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_reg(input logic [7:0] addr, input logic [15:0] exp, input string what);
		logic [15:0] got;
		read_reg(addr, got);
		expect_value(got, exp, what);
	endtask

	initial begin
		logic [15:0] val;
		logic [31:0] rnd;
		logic [7:0]  led_val;
		logic [7:0]  len;
		logic [7:0]  seed;
		logic [7:0]  byte_val;
		logic [15:0] exp_sum;
		int          exp_frames;
		int          exp_bytes;
		int          low_cycles;

		rnd = $urandom(38);
		rst_n = 1'b0;
		sclk = 1'b0;
		csb = 1'b1;
		mosi = 1'b0;
		exp_sum = '0;
		exp_frames = 0;
		exp_bytes = 0;
		repeat (5) @(posedge sysclk);
		rst_n <= 1'b1;

		// PHY reset stretch, counted on falling edges
		low_cycles = 0;
		@(negedge sysclk);
		while (!phy_rstn) begin
			low_cycles++;
			@(negedge sysclk);
		end
		expect_value(16'(low_cycles), 16'(PHY_RST_CYCLES), "phy_rstn low cycles");
		check_reg(ADDR_ID, MARBLE_ID, "ID register");

		rnd = $urandom;
		led_val = rnd[7:0];
		write_reg(ADDR_LED, {8'h00, led_val});
		expect_value({8'h00, led}, {8'h00, led_val}, "led port");
		check_reg(ADDR_LED, {8'h00, led_val}, "LED register");

		// PHY reset request and Zest power
		write_reg(ADDR_CTRL, 16'h0003);
		expect_value({14'h0000, zest_pwr_en, phy_rstn}, 16'h0002, "zest_pwr_en and phy_rstn");
		check_reg(ADDR_CTRL, 16'h0003, "CTRL register");
		write_reg(ADDR_CTRL, 16'h0000);
		expect_value({14'h0000, zest_pwr_en, phy_rstn}, 16'h0001, "zest_pwr_en and phy_rstn");

		for (int f = 0; f < 3; f++) begin
			rnd = $urandom_range(255, 1);
			len = rnd[7:0];
			rnd = $urandom;
			seed = rnd[7:0];
			write_reg(ADDR_TX_CMD, {seed, len});
			exp_frames++;
			exp_bytes += int'(len);
			byte_val = seed;
			for (int b = 0; b < int'(len); b++) begin
				exp_sum += {8'h00, byte_val};
				byte_val++;
			end
			do begin
				read_reg(ADDR_TX_CMD, val);
			end while (val[0]);
		end
		check_reg(ADDR_RX_FRAMES, 16'(exp_frames), "RX_FRAMES");
		check_reg(ADDR_RX_BYTES, 16'(exp_bytes), "RX_BYTES");
		check_reg(ADDR_RX_SUM, exp_sum, "RX_SUM");

		// Zero length leaves the engine idle and the frame count alone
		write_reg(ADDR_TX_CMD, 16'h5a00);
		check_reg(ADDR_TX_CMD, 16'h0000, "TX_CMD busy after zero length");
		check_reg(ADDR_RX_FRAMES, 16'(exp_frames), "RX_FRAMES after zero length");

		check_reg(8'h20, 16'h0000, "unmapped register");
		check_reg(ADDR_LED, {8'h00, led_val}, "LED register after unmapped read");

		$display("Run complete: %0d check errors, %0d assertion failures",
			errors, DUT.base.asserts.fail_count);
		if (errors == 0 && DUT.base.asserts.fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: flist.f
common/marble_pkg.sv
rgmii/gmii_to_rgmii.sv
base/spi_apb_bridge.sv
base/marble_regs.sv
base/frame_engine.sv
base/marble_base.sv
rtl/marble1.sv
dv/marble1_asserts.sv
dv/marble1_tb.sv

// File: Makefile
# Verilator build and run of the marble1 testbench
SIM = obj_dir/Vmarble1_tb
SRCS = $(wildcard common/*.sv rgmii/*.sv base/*.sv rtl/*.sv dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module marble1_tb -f flist.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
